//--- cache_ctrl.sv
// cache execute stage
// hit/miss FSM: acks hits, starts evict or refill on a miss,
// and writes the new tag once the line mover is done
`timescale 1ns/1ps

module cache_ctrl (
	input  logic sdram_clk,
	input  logic sys_rst,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic hit_i,
	input  logic dirty_i,
	input  logic init_busy_i,
	input  logic xfer_done_i,
	output logic ack_o,
	output logic tag_we_o,
	output logic tag_dirty_o,
	output logic evict_cmd_o,
	output logic refill_cmd_o
);

	yadmc_pkg::ctrl_state_t state;
	yadmc_pkg::ctrl_state_t next_state;
	logic                   hit_ack;
	logic                   ack_q;

	always_ff @(posedge sdram_clk) begin
		if (sys_rst) begin
			state <= yadmc_pkg::IDLE;
			ack_q <= 1'b0;
		end else begin
			state <= next_state;
			// miss ack one cycle after the mover finishes
			// gives the data array a cycle to read the new line
			ack_q <= (state == yadmc_pkg::WAIT_ACK) && xfer_done_i;
		end
	end

	always_comb begin
		next_state   = state;
		hit_ack      = 1'b0;
		tag_we_o     = 1'b0;
		tag_dirty_o  = 1'b0;
		evict_cmd_o  = 1'b0;
		refill_cmd_o = 1'b0;
		case (state)
			yadmc_pkg::IDLE: begin
				// no requests while tags are being cleared
				if (cyc_i && stb_i && !init_busy_i) begin
					next_state = yadmc_pkg::CHECK_HIT;
				end
			end
			yadmc_pkg::CHECK_HIT: begin
				if (hit_i) begin
					hit_ack = 1'b1;
					// write hit marks the line dirty
					if (we_i) begin
						tag_we_o    = 1'b1;
						tag_dirty_o = 1'b1;
					end
					next_state = yadmc_pkg::IDLE;
				end else begin
					// mover refills by itself after an eviction
					if (dirty_i) begin
						evict_cmd_o = 1'b1;
					end else begin
						refill_cmd_o = 1'b1;
					end
					next_state = yadmc_pkg::WAIT_ACK;
				end
			end
			yadmc_pkg::WAIT_ACK: begin
				// new line is in, install its tag
				if (xfer_done_i) begin
					tag_we_o    = 1'b1;
					tag_dirty_o = we_i;
				end
				if (ack_q) begin
					next_state = yadmc_pkg::IDLE;
				end
			end
			default: begin
				next_state = yadmc_pkg::IDLE;
			end
		endcase
	end

	assign ack_o = hit_ack || ack_q;

endmodule

//--- cache_decode.sv
// cache decode stage
// splits the host word address, holds the tag array and flags hit and dirty
// also gives the victim and refill line addresses to the mover
// and clears all valid bits with a sweep after reset
`timescale 1ns/1ps
`include "yadmc_settings.svh"

module cache_decode (
	input  logic                          sdram_clk,
	input  logic                          sys_rst,
	input  logic [`YADMC_ADR_BITS-1:0]    adr_i,
	input  logic                          tag_we_i,
	input  logic                          tag_dirty_i,
	output logic                          hit_o,
	output logic                          dirty_o,
	output yadmc_pkg::line_adr_t          victim_line_o,
	output yadmc_pkg::line_adr_t          refill_line_o,
	output logic                          init_busy_o
);

	localparam int lines = 1 << `YADMC_INDEX_BITS;

	logic [`YADMC_TAG_BITS-1:0]   adr_tag;
	logic [`YADMC_INDEX_BITS-1:0] adr_index;
	logic [`YADMC_INDEX_BITS-1:0] sweep_cnt;
	logic                         sweep_q;
	logic [`YADMC_INDEX_BITS-1:0] tag_adr;
	logic                         tag_we;
	yadmc_pkg::tag_entry_t        tag_wr;
	yadmc_pkg::tag_entry_t        tag_rd;

	// tag on top, index in the middle
	// offset bits select the word in the data array
	assign adr_tag   = adr_i[`YADMC_ADR_BITS-1 -: `YADMC_TAG_BITS];
	assign adr_index = adr_i[`YADMC_OFFSET_BITS +: `YADMC_INDEX_BITS];

	// reset sweep, one line per cycle
	always_ff @(posedge sdram_clk) begin
		if (sys_rst) begin
			sweep_cnt <= '0;
			sweep_q   <= 1'b1;
		end else if (sweep_q) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (sweep_cnt == '1) begin
				sweep_q <= 1'b0;
			end
		end
	end

	assign init_busy_o = sweep_q;

	// sweep owns the tag port until done
	assign tag_adr = sweep_q ? sweep_cnt : adr_index;
	assign tag_we  = sweep_q || tag_we_i;

	always_comb begin
		tag_wr = '0;
		if (!sweep_q) begin
			tag_wr.tag   = adr_tag;
			tag_wr.valid = 1'b1;
			tag_wr.dirty = tag_dirty_i;
		end
	end

	cache_ram #(
		.elem_t(yadmc_pkg::tag_entry_t),
		.depth (lines),
		.lanes (1)
	) tag_ram_inst (
		.clk_i (sdram_clk),
		.adr_i (tag_adr),
		.we_i  (tag_we),
		.wbe_i (1'b1),
		.dat_i (tag_wr),
		.dat_o (tag_rd)
	);

	assign hit_o   = tag_rd.valid && (tag_rd.tag == adr_tag);
	assign dirty_o = tag_rd.valid && tag_rd.dirty;

	// tag read and host address hold still for the whole miss
	// so these settle one cycle after the check and stay put
	always_ff @(posedge sdram_clk) begin
		victim_line_o <= {tag_rd.tag, adr_index};
		refill_line_o <= {adr_tag, adr_index};
	end

endmodule

//--- cache_ram.sv
// cache storage RAM
// single port, one cycle synchronous read, old data on a write
// element type set by parameter, split into byte lanes for writes
`timescale 1ns/1ps

module cache_ram #(
	parameter type elem_t = logic [15:0],
	parameter int  depth  = 16,
	parameter int  lanes  = 1
) (
	input  logic                     clk_i,
	input  logic [$clog2(depth)-1:0] adr_i,
	input  logic                     we_i,
	input  logic [lanes-1:0]         wbe_i,
	input  elem_t                    dat_i,
	output elem_t                    dat_o
);

	localparam int width     = $bits(elem_t);
	localparam int lane_bits = width / lanes;

	logic [width-1:0] mem [depth];
	logic [width-1:0] wr_vec;
	logic [width-1:0] rd_q;

	// flat view of the element for lane slicing
	assign wr_vec = dat_i;

	always_ff @(posedge clk_i) begin
		for (int l = 0; l < lanes; l++) begin
			if (we_i && wbe_i[l]) begin
				mem[adr_i][l*lane_bits +: lane_bits] <= wr_vec[l*lane_bits +: lane_bits];
			end
		end
		// registered read
		rd_q <= mem[adr_i];
	end

	assign dat_o = rd_q;

endmodule

//--- line_mover.sv
// cache result stage burst engine
// moves one line of 8 words between the data array and the memory port
// evict writes the victim out and then refills, refill only reads in
`timescale 1ns/1ps
`include "yadmc_settings.svh"

module line_mover (
	input  logic                                          sdram_clk,
	input  logic                                          sys_rst,
	input  logic                                          evict_cmd_i,
	input  logic                                          refill_cmd_i,
	input  yadmc_pkg::line_adr_t                          victim_line_i,
	input  yadmc_pkg::line_adr_t                          refill_line_i,
	input  yadmc_pkg::cache_word_t                        ram_dat_i,
	output logic [`YADMC_INDEX_BITS+`YADMC_OFFSET_BITS-1:0] ram_adr_o,
	output logic                                          ram_we_o,
	output yadmc_pkg::cache_word_t                        ram_dat_o,
	output logic                                          busy_o,
	output logic                                          xfer_done_o,
	output logic                                          mem_stb_o,
	output logic                                          mem_we_o,
	output logic [`YADMC_ADR_BITS-1:0]                    mem_adr_o,
	output yadmc_pkg::cache_word_t                        mem_dat_o,
	input  yadmc_pkg::cache_word_t                        mem_dat_i,
	input  logic                                          mem_ack_i
);

	// EV_RD presents the array address, EV_WR holds the memory write
	typedef enum logic [1:0] {
		M_IDLE,
		M_EV_RD,
		M_EV_WR,
		M_REFILL
	} mover_state_t;

	mover_state_t                   state;
	logic [`YADMC_OFFSET_BITS-1:0] word_cnt;
	logic                          done_q;
	logic                          evicting;
	yadmc_pkg::line_adr_t          line_sel;

	assign evicting = (state == M_EV_RD) || (state == M_EV_WR);
	assign line_sel = evicting ? victim_line_i : refill_line_i;

	// victim and refill share the index, only the tag differs
	assign ram_adr_o = {line_sel[`YADMC_INDEX_BITS-1:0], word_cnt};
	assign ram_we_o  = (state == M_REFILL) && mem_ack_i;
	assign ram_dat_o = mem_dat_i;

	// fields depend only on state and count, so they hold until ack
	assign mem_stb_o = (state == M_EV_WR) || (state == M_REFILL);
	assign mem_we_o  = (state == M_EV_WR);
	assign mem_adr_o = {line_sel, word_cnt};
	// array keeps rereading the same word while the write waits
	assign mem_dat_o = ram_dat_i;

	assign busy_o      = (state != M_IDLE);
	assign xfer_done_o = done_q;

	always_ff @(posedge sdram_clk) begin
		if (sys_rst) begin
			state    <= M_IDLE;
			word_cnt <= '0;
			done_q   <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				M_IDLE: begin
					word_cnt <= '0;
					if (evict_cmd_i) begin
						state <= M_EV_RD;
					end else if (refill_cmd_i) begin
						state <= M_REFILL;
					end
				end
				M_EV_RD: begin
					state <= M_EV_WR;
				end
				M_EV_WR: begin
					if (mem_ack_i) begin
						word_cnt <= word_cnt + 1'b1;
						// count wraps to 0 for the refill
						state <= (word_cnt == '1) ? M_REFILL : M_EV_RD;
					end
				end
				M_REFILL: begin
					if (mem_ack_i) begin
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt == '1) begin
							state  <= M_IDLE;
							done_q <= 1'b1;
						end
					end
				end
				default: begin
					state <= M_IDLE;
				end
			endcase
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build the yadmc cache testbench with Verilator and run it
# the run passes only if the pass line shows up in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_yadmc -f tb.f || exit 1
result=$(./obj_dir/Vtb_yadmc)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx "Test passed" && exit 0 || exit 1

//--- tb.f
+incdir+.
yadmc_pkg.sv
cache_ram.sv
cache_decode.sv
cache_ctrl.sv
line_mover.sv
yadmc_cache.sv
yadmc_props.sv
tb_yadmc.sv

//--- tb_yadmc.sv
// yadmc cache testbench
// host requests against a word memory model with random latency
// every read is checked against a shadow of all host writes
`timescale 1ns/1ps
`include "yadmc_settings.svh"

module tb_yadmc;

	localparam int aw        = `YADMC_ADR_BITS;
	localparam int dw        = `YADMC_DATA_BITS;
	localparam int mem_words = 1 << aw;
	// requests issued by the directed tests and by the random mix
	localparam int n_directed = 15;
	localparam int n_random   = 300;
	localparam int ack_limit  = 400;

	logic                         sdram_clk;
	logic                         sys_rst;
	logic [aw-1:0]                adr_i;
	logic [dw-1:0]                dat_i;
	logic [`YADMC_SEL_BITS-1:0]   sel_i;
	logic                         cyc_i;
	logic                         stb_i;
	logic                         we_i;
	logic [dw-1:0]                dat_o;
	logic                         ack_o;
	logic                         mem_stb_o;
	logic                         mem_we_o;
	logic [aw-1:0]                mem_adr_o;
	logic [dw-1:0]                mem_dat_o;
	logic [dw-1:0]                mem_dat_i = '0;
	logic                         mem_ack_i = 1'b0;

	logic [dw-1:0] mem_model [mem_words];
	logic [dw-1:0] shadow [mem_words];
	logic [aw-1:0] wb_adr_q [$];
	logic [dw-1:0] wb_dat_q [$];
	logic [dw-1:0] last_rdat;
	int            seed = 78343;
	int            mem_wait;
	int            mem_rd_cnt;
	int            mem_wr_cnt;
	int            errors;
	int            tests_run;
	int            tests_failed;

	yadmc_cache yadmc_cache_inst (
		.sdram_clk (sdram_clk),
		.sys_rst   (sys_rst),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.sel_i     (sel_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.mem_stb_o (mem_stb_o),
		.mem_we_o  (mem_we_o),
		.mem_adr_o (mem_adr_o),
		.mem_dat_o (mem_dat_o),
		.mem_dat_i (mem_dat_i),
		.mem_ack_i (mem_ack_i)
	);

	bind yadmc_cache yadmc_props props_inst (
		.sdram_clk (sdram_clk),
		.sys_rst   (sys_rst),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.ack_o     (ack_o),
		.mem_stb_o (mem_stb_o),
		.mem_we_o  (mem_we_o),
		.mem_adr_o (mem_adr_o),
		.mem_dat_o (mem_dat_o),
		.mem_ack_i (mem_ack_i)
	);

	initial begin
		sdram_clk = 1'b0;
		forever #20 sdram_clk = ~sdram_clk;
	end

	// start contents of memory with the low address bits repeated on top
	function automatic logic [dw-1:0] init_word(input int a);
		logic [aw-1:0] w;
		w = aw'(a);
		return {w[3:0], w} ^ 16'h5aa5;
	endfunction

	// expected word is the last host write or else the start pattern
	function automatic logic [dw-1:0] exp_read(input logic [aw-1:0] a);
		return shadow[a];
	endfunction

	// word memory acks each word after 0 to 3 idle cycles
	always @(posedge sdram_clk) begin
		mem_ack_i <= 1'b0;
		if (sys_rst) begin
			mem_wait <= 0;
		end else if (mem_stb_o && !mem_ack_i) begin
			if (mem_wait == 0) begin
				mem_ack_i <= 1'b1;
				mem_wait  <= $unsigned($random(seed)) % 4;
				if (mem_we_o) begin
					mem_model[mem_adr_o] <= mem_dat_o;
					wb_adr_q.push_back(mem_adr_o);
					wb_dat_q.push_back(mem_dat_o);
					mem_wr_cnt++;
				end else begin
					mem_dat_i <= mem_model[mem_adr_o];
					mem_rd_cnt++;
				end
			end else begin
				mem_wait <= mem_wait - 1;
			end
		end
	end

	// compare reads at each host ack and track writes per byte
	always @(negedge sdram_clk) begin
		if (!sys_rst && ack_o) begin
			if (we_i) begin
				for (int b = 0; b < `YADMC_SEL_BITS; b++) begin
					if (sel_i[b]) begin
						shadow[adr_i][b*8 +: 8] = dat_i[b*8 +: 8];
					end
				end
			end else begin
				last_rdat = dat_o;
				assert (dat_o === exp_read(adr_i)) else begin
					$display("Mismatch at time %0t: read of %h returned %h, expected %h",
						$time, adr_i, dat_o, exp_read(adr_i));
					errors++;
				end
			end
		end
	end

	// one request held until ack then one idle cycle
	task automatic host_access(input logic [aw-1:0] adr, input logic wr,
			input logic [dw-1:0] dat, input logic [1:0] sel);
		int waited;
		waited = 0;
		@(posedge sdram_clk);
		adr_i <= adr;
		dat_i <= dat;
		sel_i <= sel;
		we_i  <= wr;
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		do begin
			@(negedge sdram_clk);
			waited++;
		end while (!ack_o && waited < ack_limit);
		assert (ack_o) else begin
			$display("no acknowledge for the request at %h within %0d cycles", adr, ack_limit);
			errors++;
		end
		@(posedge sdram_clk);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		we_i  <= 1'b0;
	endtask

	// access plus the number of memory words it should move
	task automatic checked_access(input logic [aw-1:0] adr, input logic wr,
			input logic [dw-1:0] dat, input logic [1:0] sel, input int exp_rd, input int exp_wr);
		int rd0;
		int wr0;
		rd0 = mem_rd_cnt;
		wr0 = mem_wr_cnt;
		host_access(adr, wr, dat, sel);
		assert (mem_rd_cnt - rd0 == exp_rd && mem_wr_cnt - wr0 == exp_wr) else begin
			$display("Mismatch at time %0t: access to %h moved %0d/%0d read/write words, expected %0d/%0d",
				$time, adr, mem_rd_cnt - rd0, mem_wr_cnt - wr0, exp_rd, exp_wr);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	initial begin
		int            e0;
		logic [dw-1:0] old_word;
		logic [aw-1:0] a;
		logic [dw-1:0] d;
		logic          w;
		logic [1:0]    s;
		sys_rst = 1'b1;
		adr_i   = '0;
		dat_i   = '0;
		sel_i   = '0;
		cyc_i   = 1'b0;
		stb_i   = 1'b0;
		we_i    = 1'b0;
		for (int i = 0; i < mem_words; i++) begin
			mem_model[i] = init_word(i);
			shadow[i]    = init_word(i);
		end
		repeat (8) @(posedge sdram_clk);
		sys_rst <= 1'b0;

		// untouched lines
		// first ack also waits out the tag sweep
		e0 = errors;
		checked_access(12'h010, 1'b0, '0, 2'b00, 8, 0);
		checked_access(12'h025, 1'b0, '0, 2'b00, 8, 0);
		checked_access(12'h7f3, 1'b0, '0, 2'b00, 8, 0);
		finish_test("clean refill reads", e0);

		// write miss fills the line and then reads in it hit
		e0 = errors;
		checked_access(12'h030, 1'b1, 16'hbeef, 2'b11, 8, 0);
		checked_access(12'h030, 1'b0, '0, 2'b00, 0, 0);
		checked_access(12'h031, 1'b0, '0, 2'b00, 0, 0);
		checked_access(12'h037, 1'b0, '0, 2'b00, 0, 0);
		finish_test("write then hits", e0);

		// low lane first and then the high lane
		e0 = errors;
		old_word = exp_read(12'h031);
		checked_access(12'h031, 1'b1, 16'hcd12, 2'b01, 0, 0);
		checked_access(12'h031, 1'b0, '0, 2'b00, 0, 0);
		assert (last_rdat === {old_word[15:8], 8'h12}) else begin
			$display("Mismatch at time %0t: low byte write gave %h", $time, last_rdat);
			errors++;
		end
		old_word = last_rdat;
		checked_access(12'h031, 1'b1, 16'h34ab, 2'b10, 0, 0);
		checked_access(12'h031, 1'b0, '0, 2'b00, 0, 0);
		assert (last_rdat === {8'h34, old_word[7:0]}) else begin
			$display("Mismatch at time %0t: high byte write gave %h", $time, last_rdat);
			errors++;
		end
		finish_test("byte selects", e0);

		// tag 1 on index 6 pushes the dirty tag 0 line out
		e0 = errors;
		wb_adr_q.delete();
		wb_dat_q.delete();
		checked_access(12'h0b0, 1'b0, '0, 2'b00, 8, 8);
		assert (wb_adr_q.size() == 8) else begin
			$display("Mismatch at time %0t: eviction wrote %0d words instead of a full line",
				$time, wb_adr_q.size());
			errors++;
		end
		for (int i = 0; i < wb_adr_q.size(); i++) begin
			assert (wb_adr_q[i] == aw'(12'h030 + i) && wb_dat_q[i] === exp_read(aw'(12'h030 + i)))
			else begin
				$display("Mismatch at time %0t: write-back %0d went to %h with %h",
					$time, i, wb_adr_q[i], wb_dat_q[i]);
				errors++;
			end
		end
		// old line comes back from memory with the written data
		checked_access(12'h031, 1'b0, '0, 2'b00, 8, 0);
		finish_test("dirty eviction", e0);

		// line on index 6 is clean now
		e0 = errors;
		checked_access(12'h130, 1'b0, '0, 2'b00, 8, 0);
		checked_access(12'h1b5, 1'b0, '0, 2'b00, 8, 0);
		finish_test("clean conflict miss", e0);

		// four 64-word regions all on indexes 0 to 7
		e0 = errors;
		for (int n = 0; n < n_random; n++) begin
			a = aw'((($random(seed) & 3) * 128) + ($random(seed) & 63));
			w = $random(seed) & 1;
			d = dw'($random(seed));
			s = 2'($random(seed));
			host_access(a, w, d, s);
		end
		finish_test("random mix", e0);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// each request gets at most ack_limit cycles
	initial begin
		repeat (8 + (n_directed + n_random) * ack_limit) @(posedge sdram_clk);
		$display("watchdog: the run did not end in the cycles allowed for its requests");
		$display("Test failed");
		$finish;
	end

endmodule

//--- yadmc_cache.sv
// yadmc cache top
// direct mapped write-back cache of 16 lines by 8 words
// host strobe/ack port in front, word port with per-word ack to memory
`timescale 1ns/1ps
`include "yadmc_settings.svh"

module yadmc_cache (
	input  logic                         sdram_clk,
	input  logic                         sys_rst,
	input  logic [`YADMC_ADR_BITS-1:0]   adr_i,
	input  yadmc_pkg::cache_word_t       dat_i,
	input  logic [`YADMC_SEL_BITS-1:0]   sel_i,
	input  logic                         cyc_i,
	input  logic                         stb_i,
	input  logic                         we_i,
	output yadmc_pkg::cache_word_t       dat_o,
	output logic                         ack_o,
	output logic                         mem_stb_o,
	output logic                         mem_we_o,
	output logic [`YADMC_ADR_BITS-1:0]   mem_adr_o,
	output yadmc_pkg::cache_word_t       mem_dat_o,
	input  yadmc_pkg::cache_word_t       mem_dat_i,
	input  logic                         mem_ack_i
);

	localparam int data_adr_bits = `YADMC_INDEX_BITS + `YADMC_OFFSET_BITS;

	logic                             hit;
	logic                             dirty;
	logic                             init_busy;
	logic                             tag_we;
	logic                             tag_dirty;
	logic                             evict_cmd;
	logic                             refill_cmd;
	logic                             xfer_done;
	logic                             mover_busy;
	logic                             mover_we;
	yadmc_pkg::line_adr_t             victim_line;
	yadmc_pkg::line_adr_t             refill_line;
	logic [data_adr_bits-1:0]         mover_adr;
	yadmc_pkg::cache_word_t           mover_wdat;
	logic [data_adr_bits-1:0]         data_adr;
	logic                             data_we;
	logic [`YADMC_SEL_BITS-1:0]       data_wbe;
	yadmc_pkg::cache_word_t           data_wdat;
	yadmc_pkg::cache_word_t           data_rdat;

	cache_decode decode_inst (
		.sdram_clk     (sdram_clk),
		.sys_rst       (sys_rst),
		.adr_i         (adr_i),
		.tag_we_i      (tag_we),
		.tag_dirty_i   (tag_dirty),
		.hit_o         (hit),
		.dirty_o       (dirty),
		.victim_line_o (victim_line),
		.refill_line_o (refill_line),
		.init_busy_o   (init_busy)
	);

	cache_ctrl ctrl_inst (
		.sdram_clk    (sdram_clk),
		.sys_rst      (sys_rst),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.we_i         (we_i),
		.hit_i        (hit),
		.dirty_i      (dirty),
		.init_busy_i  (init_busy),
		.xfer_done_i  (xfer_done),
		.ack_o        (ack_o),
		.tag_we_o     (tag_we),
		.tag_dirty_o  (tag_dirty),
		.evict_cmd_o  (evict_cmd),
		.refill_cmd_o (refill_cmd)
	);

	line_mover mover_inst (
		.sdram_clk     (sdram_clk),
		.sys_rst       (sys_rst),
		.evict_cmd_i   (evict_cmd),
		.refill_cmd_i  (refill_cmd),
		.victim_line_i (victim_line),
		.refill_line_i (refill_line),
		.ram_dat_i     (data_rdat),
		.ram_adr_o     (mover_adr),
		.ram_we_o      (mover_we),
		.ram_dat_o     (mover_wdat),
		.busy_o        (mover_busy),
		.xfer_done_o   (xfer_done),
		.mem_stb_o     (mem_stb_o),
		.mem_we_o      (mem_we_o),
		.mem_adr_o     (mem_adr_o),
		.mem_dat_o     (mem_dat_o),
		.mem_dat_i     (mem_dat_i),
		.mem_ack_i     (mem_ack_i)
	);

	// mover owns the data array while busy
	// otherwise host index and offset, host writes land in the ack cycle
	assign data_adr  = mover_busy ? mover_adr : adr_i[data_adr_bits-1:0];
	assign data_we   = mover_busy ? mover_we : (ack_o && we_i);
	assign data_wbe  = mover_busy ? '1 : sel_i;
	assign data_wdat = mover_busy ? mover_wdat : dat_i;

	cache_ram #(
		.elem_t(yadmc_pkg::cache_word_t),
		.depth (1 << data_adr_bits),
		.lanes (`YADMC_SEL_BITS)
	) data_ram_inst (
		.clk_i (sdram_clk),
		.adr_i (data_adr),
		.we_i  (data_we),
		.wbe_i (data_wbe),
		.dat_i (data_wdat),
		.dat_o (data_rdat)
	);

	// read data valid in the ack cycle
	assign dat_o = data_rdat;

endmodule

//--- yadmc_pkg.sv
// yadmc shared types
// data words, tag entries, line addresses and the cache FSM state

`include "yadmc_settings.svh"

package yadmc_pkg;

	// one word of the line data array
	typedef logic [`YADMC_DATA_BITS-1:0] cache_word_t;

	// tag array entry
	// valid cleared by the reset sweep, dirty set by host writes
	typedef struct packed {
		logic [`YADMC_TAG_BITS-1:0] tag;
		logic                       valid;
		logic                       dirty;
	} tag_entry_t;

	// memory line address, tag on top of index
	typedef logic [`YADMC_TAG_BITS+`YADMC_INDEX_BITS-1:0] line_adr_t;

	// hit/miss FSM
	typedef enum logic [1:0] {
		IDLE,
		CHECK_HIT,
		WAIT_ACK
	} ctrl_state_t;

endpackage

//--- yadmc_props.sv
// yadmc handshake properties
// bound into the cache top, checks the host ack and the memory strobe
`timescale 1ns/1ps
`include "yadmc_settings.svh"

module yadmc_props (
	input logic                         sdram_clk,
	input logic                         sys_rst,
	input logic                         cyc_i,
	input logic                         stb_i,
	input logic                         ack_o,
	input logic                         mem_stb_o,
	input logic                         mem_we_o,
	input logic [`YADMC_ADR_BITS-1:0]   mem_adr_o,
	input logic [`YADMC_DATA_BITS-1:0]  mem_dat_o,
	input logic                         mem_ack_i
);

	// ack is a single cycle pulse
	ack_pulse: assert property (@(posedge sdram_clk) disable iff (sys_rst)
		ack_o |=> !ack_o)
		else $error("host ack held for two cycles");

	// only ack a live request
	ack_in_request: assert property (@(posedge sdram_clk) disable iff (sys_rst)
		ack_o |-> (cyc_i && stb_i))
		else $error("host ack without cyc and stb");

	// strobe and its fields hold until the word is acked
	mem_hold: assert property (@(posedge sdram_clk) disable iff (sys_rst)
		(mem_stb_o && !mem_ack_i) |=> (mem_stb_o && $stable(mem_we_o) && $stable(mem_adr_o)))
		else $error("memory strobe dropped or changed before ack");

	// write data too, read data is not driven by the cache
	mem_wdat_hold: assert property (@(posedge sdram_clk) disable iff (sys_rst)
		(mem_stb_o && mem_we_o && !mem_ack_i) |=> $stable(mem_dat_o))
		else $error("memory write data changed before ack");

endmodule

//--- yadmc_settings.svh
// yadmc cache settings
// sizes for the host address split and the data path
// a host word address is tag | index | offset
`ifndef YADMC_SETTINGS_SVH
`define YADMC_SETTINGS_SVH

// host word address, 4096 words
`define YADMC_ADR_BITS 12

// 16 cache lines
`define YADMC_INDEX_BITS 4

// word within a line, 8 words per line
`define YADMC_OFFSET_BITS 3

// what is left of the address after index and offset
`define YADMC_TAG_BITS (`YADMC_ADR_BITS - `YADMC_INDEX_BITS - `YADMC_OFFSET_BITS)

// host and memory word
`define YADMC_DATA_BITS 16

// one select per byte lane
`define YADMC_SEL_BITS 2

`endif
